// File: hdl/router_params.svh
`ifndef ROUTER_PARAMS_SVH
`define ROUTER_PARAMS_SVH

// ------------------------------------------------------------
// Router datapath sizes
// ------------------------------------------------------------
`define ROUTER_FIFO_DEPTH 16
`define ROUTER_DATA_W     32
`define ROUTER_LEN_W      12
`define ROUTER_NUM_PORTS  5

// ------------------------------------------------------------
// AXI4-Lite register map (byte addresses)
// ------------------------------------------------------------
`define ROUTER_AXI_ADDR_W 8
`define ROUTER_AXI_DATA_W 32
`define REG_CTRL          'h00
`define REG_CNT_BASE      'h04  // Counters for L, N, E, W, S follow.
`define REG_CNT_STRIDE    4

`endif

// File: hdl/router_pkg.sv
`include "router_params.svh"

package router_pkg;

  typedef logic [2:0]                      flitId_t;
  typedef logic [`ROUTER_LEN_W-1:0]        pktLen_t;  // Packet length in flits, head included.
  typedef logic [`ROUTER_DATA_W-1:0]       payload_t;
  typedef logic [`ROUTER_NUM_PORTS-1:0]    portMask_t;  // Bit 0 is L, then N, E, W, S.
  typedef logic [2:0]                      portIdx_t;
  typedef logic [`ROUTER_AXI_ADDR_W-1:0]   axiAddr_t;
  typedef logic [`ROUTER_AXI_DATA_W-1:0]   axiData_t;
  typedef logic [`ROUTER_AXI_DATA_W/8-1:0] axiStrb_t;
  typedef logic [1:0]                      axiResp_t;

  localparam flitId_t  FLIT_HEAD = 3'd1;
  localparam axiResp_t AXI_OKAY  = 2'b00;

  // Only the head flit carries a meaningful len.
  typedef struct packed {
    flitId_t  id;
    pktLen_t  len;
    payload_t data;
  } flit_t;

  // ARB_L to ARB_S hold the output for that input port.
  typedef enum logic [2:0] {
    ARB_IDLE,
    ARB_L,
    ARB_N,
    ARB_E,
    ARB_W,
    ARB_S
  } arbState_t;

  typedef struct packed {
    logic     done;  // High in the cycle the last flit leaves.
    portIdx_t port;
  } pktEvent_t;

endpackage

// File: hdl/flit_fifo.sv
`timescale 1ns/1ps
`include "router_params.svh"

module flit_fifo (
  input  logic              clk,
  input  logic              rst,
  input  router_pkg::flit_t inFlit,
  input  logic              inValid,
  output logic              inReady,
  output router_pkg::flit_t headFlit,
  output logic              notEmpty,
  input  logic              pop
);

  localparam int Depth = `ROUTER_FIFO_DEPTH;
  localparam int PtrW  = $clog2(Depth);

  router_pkg::flit_t mem [Depth];
  logic [PtrW-1:0]   wrPtr;
  logic [PtrW-1:0]   rdPtr;
  logic [PtrW:0]     count;
  logic [PtrW:0]     countNext;
  logic              push;

  assign push     = inValid && inReady;
  assign notEmpty = (count != '0);
  assign headFlit = mem[rdPtr];

  always_comb
  begin
    countNext = count;
    if (push && !pop)
      countNext = count + 1'b1;
    else if (pop && !push)
      countNext = count - 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr   <= '0;
      rdPtr   <= '0;
      count   <= '0;
      inReady <= 1'b0;
    end
    else
    begin
      if (push)
        wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
      if (pop)
        rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
      count   <= countNext;
      inReady <= (countNext != (PtrW + 1)'(Depth));  // Registered, so it looks one flit ahead.
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= inFlit;
  end

  // The arbiter must only pop a port it sees as not empty.
  a_popNotEmpty : assert property (@(posedge clk) disable iff (rst) pop |-> notEmpty);

endmodule

// File: hdl/port_timer.sv
`timescale 1ns/1ps

module port_timer (
  input  logic              clk,
  input  logic              rst,
  input  router_pkg::flit_t flit,
  input  logic              step,
  output logic              lastFlit
);

  router_pkg::pktLen_t pktLen;  // Length latched from the head flit.
  router_pkg::pktLen_t count;   // Flits of the current packet sent so far.
  logic                isHead;

  assign isHead = (flit.id == router_pkg::FLIT_HEAD);

  // A one-flit packet ends on its own head.
  always_comb
  begin
    if (isHead)
      lastFlit = step && (flit.len <= router_pkg::pktLen_t'(1));
    else
      lastFlit = step && (count + router_pkg::pktLen_t'(1) == pktLen);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pktLen <= '0;
      count  <= '0;
    end
    else if (step)
    begin
      if (isHead)
      begin
        pktLen <= flit.len;
        count  <= router_pkg::pktLen_t'(1);
      end
      else
        count <= count + router_pkg::pktLen_t'(1);  // Held while the link stalls.
    end
  end

endmodule

// File: hdl/packet_arbiter.sv
`timescale 1ns/1ps
`include "router_params.svh"

module packet_arbiter (
  input  logic                  clk,
  input  logic                  rst,
  input  router_pkg::flit_t     headFlit [`ROUTER_NUM_PORTS],
  input  router_pkg::portMask_t notEmpty,
  input  router_pkg::portMask_t portEnable,
  output router_pkg::portMask_t pop,
  output router_pkg::flit_t     outFlit,
  output router_pkg::portIdx_t  outPort,
  output logic                  outValid,
  input  logic                  outReady,
  output router_pkg::pktEvent_t pktEvent
);

  localparam int NumPorts = `ROUTER_NUM_PORTS;

  router_pkg::arbState_t state;
  router_pkg::arbState_t stateNext;
  router_pkg::portIdx_t  grantIdx;
  router_pkg::portMask_t grantMask;
  router_pkg::portMask_t req;
  router_pkg::portMask_t lastFlit;
  logic                  granted;
  logic                  xfer;
  logic                  pktDone;

  // Walks the ports cyclically from start; the first candidate found wins.
  function automatic router_pkg::arbState_t pickNext(router_pkg::portMask_t cand, int start);
    router_pkg::arbState_t pick;
    int                    idx;
    pick = router_pkg::ARB_IDLE;
    for (int k = NumPorts - 1; k >= 0; k--)
    begin
      idx = (start + k) % NumPorts;
      if (cand[idx])
        pick = router_pkg::arbState_t'(idx + 1);
    end
    return pick;
  endfunction

  // ------------------------------------------------------------
  // Grant decode and output mux
  // ------------------------------------------------------------
  assign granted   = (state != router_pkg::ARB_IDLE);
  assign grantIdx  = granted ? router_pkg::portIdx_t'(int'(state) - 1) : '0;
  assign grantMask = granted ? (router_pkg::portMask_t'(1) << grantIdx) : '0;

  assign outFlit  = headFlit[grantIdx];
  assign outPort  = grantIdx;
  assign outValid = granted && notEmpty[grantIdx];  // Body flits may lag behind the head.
  assign xfer     = outValid && outReady;
  assign pop      = xfer ? grantMask : '0;

  assign pktDone  = |lastFlit;
  assign pktEvent = '{done: pktDone, port: grantIdx};

  always_comb
  begin
    for (int i = 0; i < NumPorts; i++)
      req[i] = notEmpty[i] && (headFlit[i].id == router_pkg::FLIT_HEAD) && portEnable[i];
  end

  // ------------------------------------------------------------
  // Flit timers, stepped only by the granted port's transfers
  // ------------------------------------------------------------
  for (genvar i = 0; i < NumPorts; i++)
  begin : gTimer
    port_timer u_port_timer (
      .clk      (clk),
      .rst      (rst),
      .flit     (headFlit[i]),
      .step     (pop[i]),
      .lastFlit (lastFlit[i])
    );
  end

  // ------------------------------------------------------------
  // Rotating-priority state machine
  // ------------------------------------------------------------
  always_comb
  begin
    stateNext = state;
    if (!granted)
      stateNext = pickNext(req, 0);  // L first down to S.
    else if (pktDone)
      // The granted port's head is the flit now leaving, so it cannot bid yet.
      stateNext = pickNext(req & ~grantMask, int'(grantIdx) + 1);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= router_pkg::ARB_IDLE;
    else
      state <= stateNext;
  end

  a_popOneHot : assert property (@(posedge clk) disable iff (rst) $onehot0(pop));

  // A stalled flit must be held on the link until it is taken.
  a_outStable : assert property (@(posedge clk) disable iff (rst)
    outValid && !outReady |=> outValid && $stable(outFlit) && $stable(outPort));

endmodule

// File: hdl/arb_config_regs.sv
`timescale 1ns/1ps
`include "router_params.svh"

module arb_config_regs (
  input  logic                  clk,
  input  logic                  rst,
  input  router_pkg::axiAddr_t  awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  router_pkg::axiData_t  wdata,
  input  router_pkg::axiStrb_t  wstrb,
  input  logic                  wvalid,
  output logic                  wready,
  output router_pkg::axiResp_t  bresp,
  output logic                  bvalid,
  input  logic                  bready,
  input  router_pkg::axiAddr_t  araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output router_pkg::axiData_t  rdata,
  output router_pkg::axiResp_t  rresp,
  output logic                  rvalid,
  input  logic                  rready,
  input  router_pkg::pktEvent_t pktEvent,
  output router_pkg::portMask_t portEnable
);

  localparam int NumPorts = `ROUTER_NUM_PORTS;

  router_pkg::axiAddr_t  awAddrQ;
  router_pkg::axiData_t  wDataQ;
  router_pkg::axiStrb_t  wStrbQ;
  router_pkg::axiAddr_t  wrAddr;
  router_pkg::axiData_t  wrData;
  router_pkg::axiStrb_t  wrStrb;
  router_pkg::axiData_t  readData;
  router_pkg::axiData_t  pktCount [NumPorts];
  router_pkg::portMask_t enableMask;
  logic                  awPending;
  logic                  wPending;
  logic                  awFire;
  logic                  wFire;
  logic                  arFire;
  logic                  doWrite;

  // ------------------------------------------------------------
  // Write channel; AW and W may arrive in either order
  // ------------------------------------------------------------
  assign awready = !awPending && !bvalid;
  assign wready  = !wPending && !bvalid;
  assign awFire  = awvalid && awready;
  assign wFire   = wvalid && wready;
  assign doWrite = (awPending || awFire) && (wPending || wFire);

  assign wrAddr = awPending ? awAddrQ : awaddr;
  assign wrData = wPending ? wDataQ : wdata;
  assign wrStrb = wPending ? wStrbQ : wstrb;
  assign bresp  = router_pkg::AXI_OKAY;  // Counter writes are dropped silently.

  // ------------------------------------------------------------
  // Read channel
  // ------------------------------------------------------------
  assign arready = !rvalid;
  assign arFire  = arvalid && arready;
  assign rresp   = router_pkg::AXI_OKAY;

  always_comb
  begin
    readData = '0;  // Unmapped addresses read as zero.
    if (araddr == router_pkg::axiAddr_t'(`REG_CTRL))
      readData = router_pkg::axiData_t'(enableMask);
    for (int i = 0; i < NumPorts; i++)
    begin
      if (araddr == router_pkg::axiAddr_t'(`REG_CNT_BASE + `REG_CNT_STRIDE * i))
        readData = pktCount[i];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      awPending  <= 1'b0;
      wPending   <= 1'b0;
      bvalid     <= 1'b0;
      rvalid     <= 1'b0;
      enableMask <= '1;
      for (int i = 0; i < NumPorts; i++)
        pktCount[i] <= '0;
    end
    else
    begin
      if (bvalid && bready)
        bvalid <= 1'b0;
      if (doWrite)
      begin
        awPending <= 1'b0;
        wPending  <= 1'b0;
        bvalid    <= 1'b1;
        if (wrAddr == router_pkg::axiAddr_t'(`REG_CTRL) && wrStrb[0])
          enableMask <= wrData[NumPorts-1:0];
      end
      else
      begin
        if (awFire)
          awPending <= 1'b1;
        if (wFire)
          wPending <= 1'b1;
      end
      if (rvalid && rready)
        rvalid <= 1'b0;
      if (arFire)
        rvalid <= 1'b1;
      for (int i = 0; i < NumPorts; i++)
      begin
        if (pktEvent.done && pktEvent.port == router_pkg::portIdx_t'(i))
          pktCount[i] <= pktCount[i] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (awFire)
      awAddrQ <= awaddr;
    if (wFire)
    begin
      wDataQ <= wdata;
      wStrbQ <= wstrb;
    end
    if (arFire)
      rdata <= readData;
  end

  assign portEnable = enableMask;

  a_bvalidHold : assert property (@(posedge clk) disable iff (rst)
    bvalid && !bready |=> bvalid);

endmodule

// File: hdl/router_output_port.sv
`timescale 1ns/1ps
`include "router_params.svh"

module router_output_port (
  input  logic                 clk,
  input  logic                 rst,
  input  router_pkg::flit_t    lInFlit,
  input  logic                 lInValid,
  output logic                 lInReady,
  input  router_pkg::flit_t    nInFlit,
  input  logic                 nInValid,
  output logic                 nInReady,
  input  router_pkg::flit_t    eInFlit,
  input  logic                 eInValid,
  output logic                 eInReady,
  input  router_pkg::flit_t    wInFlit,
  input  logic                 wInValid,
  output logic                 wInReady,
  input  router_pkg::flit_t    sInFlit,
  input  logic                 sInValid,
  output logic                 sInReady,
  output router_pkg::flit_t    outFlit,
  output router_pkg::portIdx_t outPort,
  output logic                 outValid,
  input  logic                 outReady,
  input  router_pkg::axiAddr_t awaddr,
  input  logic                 awvalid,
  output logic                 awready,
  input  router_pkg::axiData_t wdata,
  input  router_pkg::axiStrb_t wstrb,
  input  logic                 wvalid,
  output logic                 wready,
  output router_pkg::axiResp_t bresp,
  output logic                 bvalid,
  input  logic                 bready,
  input  router_pkg::axiAddr_t araddr,
  input  logic                 arvalid,
  output logic                 arready,
  output router_pkg::axiData_t rdata,
  output router_pkg::axiResp_t rresp,
  output logic                 rvalid,
  input  logic                 rready
);

  localparam int NumPorts = `ROUTER_NUM_PORTS;

  router_pkg::flit_t     inFlitArr [NumPorts];
  router_pkg::flit_t     headFlit  [NumPorts];
  router_pkg::portMask_t inValidVec;
  router_pkg::portMask_t inReadyVec;
  router_pkg::portMask_t notEmpty;
  router_pkg::portMask_t pop;
  router_pkg::portMask_t portEnable;
  router_pkg::pktEvent_t pktEvent;

  // Port order L, N, E, W, S matches the mask bits.
  assign inFlitArr[0] = lInFlit;
  assign inFlitArr[1] = nInFlit;
  assign inFlitArr[2] = eInFlit;
  assign inFlitArr[3] = wInFlit;
  assign inFlitArr[4] = sInFlit;
  assign inValidVec   = {sInValid, wInValid, eInValid, nInValid, lInValid};
  assign {sInReady, wInReady, eInReady, nInReady, lInReady} = inReadyVec;

  for (genvar i = 0; i < NumPorts; i++)
  begin : gFifo
    flit_fifo u_flit_fifo (
      .clk      (clk),
      .rst      (rst),
      .inFlit   (inFlitArr[i]),
      .inValid  (inValidVec[i]),
      .inReady  (inReadyVec[i]),
      .headFlit (headFlit[i]),
      .notEmpty (notEmpty[i]),
      .pop      (pop[i])
    );
  end

  packet_arbiter u_packet_arbiter (
    .clk        (clk),
    .rst        (rst),
    .headFlit   (headFlit),
    .notEmpty   (notEmpty),
    .portEnable (portEnable),
    .pop        (pop),
    .outFlit    (outFlit),
    .outPort    (outPort),
    .outValid   (outValid),
    .outReady   (outReady),
    .pktEvent   (pktEvent)
  );

  arb_config_regs u_arb_config_regs (
    .clk        (clk),
    .rst        (rst),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .pktEvent   (pktEvent),
    .portEnable (portEnable)
  );

endmodule

// File: verif/tb_router_output_port.sv
`timescale 1ns/1ps
`include "router_params.svh"

module tb_router_output_port;

  localparam int NumPorts    = `ROUTER_NUM_PORTS;
  localparam int NumPkts     = 8;  // Packets per port in the random test.
  localparam int WatchdogNs  = NumPkts * 4 * NumPorts * 8 + 20000;
  localparam int ReadyHigh   = 0;
  localparam int ReadyLow    = 1;
  localparam int ReadyRandom = 2;

  logic                  clk;
  logic                  rst;
  router_pkg::flit_t     inFlit [NumPorts];
  logic [NumPorts-1:0]   inValid;
  logic [NumPorts-1:0]   inReady;
  router_pkg::flit_t     outFlit;
  router_pkg::portIdx_t  outPort;
  logic                  outValid;
  logic                  outReady;
  router_pkg::axiAddr_t  awaddr;
  logic                  awvalid;
  logic                  awready;
  router_pkg::axiData_t  wdata;
  router_pkg::axiStrb_t  wstrb;
  logic                  wvalid;
  logic                  wready;
  router_pkg::axiResp_t  bresp;
  logic                  bvalid;
  logic                  bready;
  router_pkg::axiAddr_t  araddr;
  logic                  arvalid;
  logic                  arready;
  router_pkg::axiData_t  rdata;
  router_pkg::axiResp_t  rresp;
  logic                  rvalid;
  logic                  rready;

  // Reference model state, owned by the monitor.
  router_pkg::flit_t     expQ [NumPorts][$];
  router_pkg::portIdx_t  pktOrder [$];
  int                    pktDelivered [NumPorts];
  int                    remaining;
  router_pkg::portIdx_t  curPort;
  logic                  stallSeen;
  router_pkg::flit_t     heldFlit;
  router_pkg::portIdx_t  heldPort;
  int                    monErrors;

  int                    errors;
  int                    testsRun;
  int                    testsFailed;
  int                    readyMode;
  logic [31:0]           rngState;

  router_output_port u_router_output_port (
    .clk (clk), .rst (rst),
    .lInFlit (inFlit[0]), .lInValid (inValid[0]), .lInReady (inReady[0]),
    .nInFlit (inFlit[1]), .nInValid (inValid[1]), .nInReady (inReady[1]),
    .eInFlit (inFlit[2]), .eInValid (inValid[2]), .eInReady (inReady[2]),
    .wInFlit (inFlit[3]), .wInValid (inValid[3]), .wInReady (inReady[3]),
    .sInFlit (inFlit[4]), .sInValid (inValid[4]), .sInReady (inReady[4]),
    .outFlit (outFlit), .outPort (outPort), .outValid (outValid), .outReady (outReady),
    .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
    .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
    .bresp (bresp), .bvalid (bvalid), .bready (bready),
    .araddr (araddr), .arvalid (arvalid), .arready (arready),
    .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] nextRand();
    rngState = xorshift(rngState);
    return rngState;
  endfunction

  function automatic int totalErrors();
    return errors + monErrors;
  endfunction

  task automatic showMismatch(input string name, input logic [63:0] got, input logic [63:0] exp);
    $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
  endtask

  // ------------------------------------------------------------
  // Clock, output-ready driver and watchdog
  // ------------------------------------------------------------
  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial
  begin : readyDriver
    int          mode;
    logic [31:0] readyRng;
    outReady = 1'b0;
    readyRng = ~32'hb07e;
    forever
    begin
      @(posedge clk);
      mode = readyMode;  // Sampled on the edge, applied 1 ns later.
      #1;
      readyRng = xorshift(readyRng);
      if (mode == ReadyRandom)
        outReady = (readyRng[1:0] != 2'b00);
      else
        outReady = (mode == ReadyHigh);
    end
  end

  initial
  begin
    #(WatchdogNs);
    $display("Timeout: the run did not finish within %0d ns", WatchdogNs);
    $display("Something failed");
    $finish;
  end

  // ------------------------------------------------------------
  // Monitor: input capture, output checks, wormhole tracking
  // ------------------------------------------------------------
  always @(negedge clk)
  begin : monitor
    router_pkg::flit_t expFlit;
    if (!rst)
    begin
      for (int i = 0; i < NumPorts; i++)
      begin
        if (inValid[i] && inReady[i])
          expQ[i].push_back(inFlit[i]);
      end
      if (stallSeen)
      begin
        if (!outValid)
        begin
          $display("outValid dropped while the link was stalled");
          monErrors++;
        end
        else if (outFlit !== heldFlit)
        begin
          showMismatch("outFlit under stall", 64'(outFlit), 64'(heldFlit));
          monErrors++;
        end
        else if (outPort !== heldPort)
        begin
          showMismatch("outPort under stall", 64'(outPort), 64'(heldPort));
          monErrors++;
        end
      end
      if (outValid && outReady)
      begin
        if (remaining == 0)
        begin
          if (outFlit.id != router_pkg::FLIT_HEAD)
          begin
            $display("A non-head flit from port %0d started a packet", outPort);
            monErrors++;
          end
          remaining = int'(outFlit.len);
          curPort   = outPort;
          pktOrder.push_back(outPort);
        end
        else if (outPort != curPort)
        begin
          showMismatch("outPort", 64'(outPort), 64'(curPort));  // Wormhole broken.
          monErrors++;
        end
        if (expQ[outPort].size() == 0)
        begin
          $display("Port %0d sent a flit that was never injected", outPort);
          monErrors++;
        end
        else
        begin
          expFlit = expQ[outPort].pop_front();
          if (outFlit !== expFlit)
          begin
            showMismatch("outFlit", 64'(outFlit), 64'(expFlit));
            monErrors++;
          end
        end
        remaining = remaining - 1;
        if (remaining <= 0)
        begin
          remaining = 0;
          pktDelivered[outPort]++;
        end
      end
      stallSeen = outValid && !outReady;
      heldFlit  = outFlit;
      heldPort  = outPort;
    end
  end

  // ------------------------------------------------------------
  // Stimulus tasks
  // ------------------------------------------------------------
  task automatic idleCycles(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic sendFlit(input int p, input router_pkg::flit_t f);
    inFlit[p]  = f;
    inValid[p] = 1'b1;
    @(negedge clk);
    while (!inReady[p])
      @(negedge clk);
    @(posedge clk);
    #1;
    inValid[p] = 1'b0;
  endtask

  task automatic sendPacket(input int p, input int len);
    router_pkg::flit_t f;
    for (int k = 0; k < len; k++)
    begin
      if (k == 0)
        f.id = router_pkg::FLIT_HEAD;
      else
        f.id = (k == len - 1) ? 3'd3 : 3'd2;
      f.len  = (k == 0) ? router_pkg::pktLen_t'(len) : '0;
      f.data = nextRand();
      sendFlit(p, f);
      if (nextRand() % 4 == 0)
        idleCycles(1);  // Lets body flits lag behind the head.
    end
  endtask

  task automatic runTraffic(input int p);
    repeat (NumPkts)
    begin
      sendPacket(p, 1 + int'(nextRand() % 4));
      idleCycles(int'(nextRand() % 3));
    end
  endtask

  task automatic axiWrite(input router_pkg::axiAddr_t addr, input router_pkg::axiData_t data);
    logic awHit;
    logic wHit;
    logic bHit;
    int   cnt;
    awaddr  = addr;
    wdata   = data;
    wstrb   = '1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    cnt     = 0;
    bHit    = 1'b0;
    while (!bHit && cnt < 20)
    begin
      @(negedge clk);
      awHit = awvalid && awready;
      wHit  = wvalid && wready;
      bHit  = bvalid;
      if (bHit && bresp != router_pkg::AXI_OKAY)
      begin
        showMismatch("bresp", 64'(bresp), 64'(router_pkg::AXI_OKAY));
        errors++;
      end
      @(posedge clk);
      #1;
      if (awHit)
        awvalid = 1'b0;
      if (wHit)
        wvalid = 1'b0;
      cnt++;
    end
    bready = 1'b0;
    if (!bHit)
    begin
      $display("No write response for address 0x%0h", addr);
      errors++;
    end
  endtask

  task automatic axiRead(input router_pkg::axiAddr_t addr, output router_pkg::axiData_t data);
    logic arHit;
    logic rHit;
    int   cnt;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    data    = '0;
    cnt     = 0;
    rHit    = 1'b0;
    while (!rHit && cnt < 20)
    begin
      @(negedge clk);
      arHit = arvalid && arready;
      rHit  = rvalid;
      if (rHit)
      begin
        data = rdata;
        if (rresp != router_pkg::AXI_OKAY)
        begin
          showMismatch("rresp", 64'(rresp), 64'(router_pkg::AXI_OKAY));
          errors++;
        end
      end
      @(posedge clk);
      #1;
      if (arHit)
        arvalid = 1'b0;
      cnt++;
    end
    rready = 1'b0;
    if (!rHit)
    begin
      $display("No read data for address 0x%0h", addr);
      errors++;
    end
  endtask

  task automatic waitGrant(input int p, input int maxCycles);
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (!(outValid && outPort == router_pkg::portIdx_t'(p)) && cnt < maxCycles)
    begin
      @(negedge clk);
      cnt++;
    end
    if (cnt >= maxCycles)
    begin
      $display("Port %0d was never granted the output", p);
      errors++;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic waitDrained(input logic [NumPorts-1:0] mask, input int maxCycles);
    int   cnt;
    logic empty;
    cnt   = 0;
    empty = 1'b0;
    while (!empty && cnt < maxCycles)
    begin
      @(negedge clk);
      empty = 1'b1;
      for (int i = 0; i < NumPorts; i++)
      begin
        if (mask[i] && expQ[i].size() != 0)
          empty = 1'b0;
      end
      cnt++;
    end
    if (!empty)
    begin
      $display("Flits were still waiting after %0d cycles", maxCycles);
      errors++;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic endTest(input string name, input int errBefore);
    testsRun++;
    if (totalErrors() == errBefore)
      $display("Test %s: passed", name);
    else
    begin
      testsFailed++;
      $display("Test %s: FAILED", name);
    end
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial
  begin : mainSequence
    router_pkg::axiData_t data;
    int                   errBefore;
    int                   orderStart;
    int                   wBefore;
    rngState  = 32'hb07e;
    readyMode = ReadyHigh;
    errors    = 0;
    monErrors = 0;
    testsRun  = 0;
    testsFailed = 0;
    remaining = 0;
    curPort   = '0;
    stallSeen = 1'b0;
    heldFlit  = '0;
    heldPort  = '0;
    inValid   = '0;
    for (int i = 0; i < NumPorts; i++)
    begin
      inFlit[i]       = '0;
      pktDelivered[i] = 0;
    end
    {awaddr, awvalid, wdata, wstrb, wvalid, bready} = '0;
    {araddr, arvalid, rready} = '0;
    rst = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    idleCycles(2);

    errBefore = totalErrors();
    axiRead(`REG_CTRL, data);
    if (data !== 32'h1F)
    begin
      showMismatch("CTRL", 64'(data), 64'h1F);
      errors++;
    end
    for (int i = 0; i < NumPorts; i++)
    begin
      axiRead(router_pkg::axiAddr_t'(`REG_CNT_BASE + `REG_CNT_STRIDE * i), data);
      if (data !== 32'h0)
      begin
        showMismatch("packet counter", 64'(data), 64'h0);
        errors++;
      end
    end
    axiWrite(router_pkg::axiAddr_t'(`REG_CNT_BASE + `REG_CNT_STRIDE), 32'hABCD);
    axiRead(router_pkg::axiAddr_t'(`REG_CNT_BASE + `REG_CNT_STRIDE), data);
    if (data !== 32'h0)
    begin
      showMismatch("N packet counter after write", 64'(data), 64'h0);
      errors++;
    end
    endTest("register reset values", errBefore);

    // All five heads wait together, so priority alone decides the order.
    errBefore  = totalErrors();
    orderStart = pktOrder.size();
    axiWrite(`REG_CTRL, 32'h0);
    fork
      sendPacket(0, 2);
      sendPacket(1, 2);
      sendPacket(2, 2);
      sendPacket(3, 2);
      sendPacket(4, 2);
    join
    idleCycles(5);
    if (pktOrder.size() != orderStart)
    begin
      $display("A packet left while every port was disabled");
      errors++;
    end
    axiWrite(`REG_CTRL, 32'h1F);
    waitDrained('1, 100);
    for (int i = 0; i < NumPorts; i++)
    begin
      if (pktOrder.size() <= orderStart + i)
      begin
        $display("Only %0d of 5 packets left", pktOrder.size() - orderStart);
        errors++;
        break;
      end
      else if (pktOrder[orderStart + i] != router_pkg::portIdx_t'(i))
      begin
        showMismatch("outPort order", 64'(pktOrder[orderStart + i]), 64'(i));
        errors++;
      end
    end
    endTest("ordering", errBefore);

    errBefore = totalErrors();
    readyMode = ReadyLow;
    axiWrite(`REG_CTRL, 32'h1B);  // East off.
    sendPacket(2, 2);
    sendPacket(3, 4);
    waitGrant(3, 50);
    wBefore   = pktDelivered[3];
    readyMode = ReadyHigh;  // Exactly one flit of the west packet goes out.
    idleCycles(1);
    readyMode = ReadyLow;
    axiWrite(`REG_CTRL, 32'h13);
    readyMode = ReadyHigh;
    waitDrained(5'b01000, 100);
    if (pktDelivered[3] != wBefore + 1)
    begin
      $display("The west packet did not finish after its port was disabled");
      errors++;
    end
    idleCycles(10);
    if (expQ[2].size() != 2)
    begin
      showMismatch("east flits waiting", 64'(expQ[2].size()), 64'd2);
      errors++;
    end
    axiWrite(`REG_CTRL, 32'h1F);
    waitDrained('1, 100);
    endTest("enable mask", errBefore);

    errBefore = totalErrors();
    readyMode = ReadyRandom;
    fork
      runTraffic(0);
      runTraffic(1);
      runTraffic(2);
      runTraffic(3);
      runTraffic(4);
    join
    waitDrained('1, NumPkts * 4 * NumPorts * 4);
    readyMode = ReadyHigh;
    idleCycles(2);
    endTest("random traffic and back-pressure", errBefore);

    errBefore = totalErrors();
    for (int i = 0; i < NumPorts; i++)
    begin
      axiRead(router_pkg::axiAddr_t'(`REG_CNT_BASE + `REG_CNT_STRIDE * i), data);
      if (data !== router_pkg::axiData_t'(pktDelivered[i]))
      begin
        showMismatch("packet counter", 64'(data), 64'(pktDelivered[i]));
        errors++;
      end
    end
    endTest("counters", errBefore);

    $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, totalErrors());
    if (testsFailed == 0 && totalErrors() == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// File: files.f
+incdir+hdl
hdl/router_pkg.sv
hdl/flit_fifo.sv
hdl/port_timer.sv
hdl/packet_arbiter.sv
hdl/arb_config_regs.sv
hdl/router_output_port.sv
verif/tb_router_output_port.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_router_output_port
FILELIST = files.f
LOG      = sim.log
PASS_MSG = Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
